// File: dv/cache_checks.svh
// Compare tasks and reference-model helpers, included into the cache testbench module
`ifndef CACHE_CHECKS_SVH
`define CACHE_CHECKS_SVH

task automatic check_data(input string name, input cache_pkg::data_t got,
                          input cache_pkg::data_t exp);
  if (got !== exp) begin
    abort_run($sformatf("[ERROR] time %0t ns  %s  got %h  expected %h", $time, name, got, exp));
  end
endtask

task automatic check_addr(input string name, input cache_pkg::addr_t got,
                          input cache_pkg::addr_t exp);
  if (got !== exp) begin
    abort_run($sformatf("[ERROR] time %0t ns  %s  got %h  expected %h", $time, name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("[ERROR] time %0t ns  %s  got %b  expected %b", $time, name, got, exp));
  end
endtask

// Address fields of a word address
function automatic logic [line_bits-1:0] line_of(input cache_pkg::addr_t a);
  return a[word_bits +: line_bits];
endfunction

function automatic logic [tag_w-1:0] tag_of(input cache_pkg::addr_t a);
  return a[cache_pkg::addr_w-1 -: tag_w];
endfunction

// First word of the line as sent with a refill read
function automatic cache_pkg::addr_t line_base(input cache_pkg::addr_t a);
  return {tag_of(a), line_of(a), {word_bits{1'b0}}};
endfunction

// Hit when the shadow holds a valid line with a matching tag
function automatic logic predict_hit(input cache_pkg::addr_t a);
  return shadow_valid[line_of(a)] && (shadow_tag[line_of(a)] == tag_of(a));
endfunction

// Only a read miss allocates a line
task automatic note_refill(input cache_pkg::addr_t a);
  shadow_valid[line_of(a)] = 1'b1;
  shadow_tag[line_of(a)]   = tag_of(a);
endtask

`endif

// File: dv/cache_tb.sv
// Self-checking testbench for the cache top level with a backing memory model and LFSR stimulus
`timescale 1ns/1ns

module cache_tb;

  localparam int line_bits      = 3;
  localparam int word_bits      = 2;
  localparam int timeout_cycles = 64;
  localparam int tag_w          = cache_pkg::addr_w - line_bits - word_bits;
  localparam int lines          = 1 << line_bits;
  localparam int resp_limit     = 200;
  localparam int random_ops     = 500;

  logic             clk;
  logic             arst_n;
  logic             req_rd;
  logic             req_wr;
  cache_pkg::addr_t req_addr;
  cache_pkg::data_t req_wdata;
  logic             busy;
  logic             resp_valid;
  cache_pkg::data_t resp_rdata;
  logic             err;
  logic             mem_rd;
  logic             mem_wr;
  cache_pkg::addr_t mem_addr;
  cache_pkg::data_t mem_wdata;
  logic             mem_rvalid;
  cache_pkg::data_t mem_rdata;

  // Backing memory and the expected view of it
  cache_pkg::data_t model_mem [0:255];
  cache_pkg::data_t ref_mem [0:255];
  logic [lines-1:0] shadow_valid;
  logic [tag_w-1:0] shadow_tag [0:lines-1];
  logic             mem_silent;
  logic [31:0]      lfsr_state = 32'h252ff944;

  // Memory-side activity seen at each rising edge
  int               cycle_no = 0;
  int               rd_count = 0;
  int               wr_count = 0;
  int               rd_cycle = 0;
  cache_pkg::addr_t rd_addr  = '0;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] next_bits(input int count);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < count; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  `include "cache_checks.svh"

  cache_top #(
    .line_bits      (line_bits),
    .word_bits      (word_bits),
    .timeout_cycles (timeout_cycles)
  ) cache_top_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_rd     (req_rd),
    .req_wr     (req_wr),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .err        (err),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_no = cycle_no + 1;
    if (mem_rd) begin
      rd_count = rd_count + 1;
      rd_addr  = mem_addr;
      rd_cycle = cycle_no;
    end
    if (mem_wr) begin
      wr_count = wr_count + 1;
    end
  end

  // Word-wide memory, four beats per line read with random gaps
  initial begin : memory_model
    cache_pkg::addr_t base;
    int               gap;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    #1;
    for (int i = 0; i < 256; i++) begin
      model_mem[cache_pkg::addr_t'(i)] = ref_mem[cache_pkg::addr_t'(i)];
    end
    forever begin
      @(posedge clk);
      if (mem_wr) begin
        model_mem[mem_addr] = mem_wdata;
      end
      if (mem_rd && !mem_silent) begin
        base = mem_addr;
        for (int b = 0; b < 4; b++) begin
          gap = int'(next_bits(2));
          repeat (gap) begin
            #5;
            mem_rvalid = 1'b0;
            @(posedge clk);
          end
          #5;
          mem_rvalid = 1'b1;
          mem_rdata  = model_mem[base + cache_pkg::addr_t'(b)];
          @(posedge clk);
        end
        #5;
        mem_rvalid = 1'b0;
      end
    end
  end

  // Entered and left 5 ns after a rising edge
  task automatic wait_idle();
    int n = 0;
    while (busy) begin
      @(posedge clk);
      #5;
      n++;
      if (n > resp_limit) begin
        abort_run("Timeout while waiting for busy to fall");
      end
    end
  endtask

  task automatic issue_read(input cache_pkg::addr_t a);
    wait_idle();
    req_rd   = 1'b1;
    req_addr = a;
    @(posedge clk);
    #5;
    req_rd = 1'b0;
  endtask

  task automatic read_word(input cache_pkg::addr_t a);
    logic expect_hit;
    int   rd_before;
    int   c0;
    int   edges;
    expect_hit = predict_hit(a);
    rd_before  = rd_count;
    issue_read(a);
    c0    = cycle_no;
    edges = 0;
    while (!resp_valid) begin
      @(posedge clk);
      #5;
      edges++;
      if (edges > resp_limit) begin
        abort_run($sformatf("Timeout waiting for the response to the read of %h", a));
      end
    end
    check_data("resp_rdata", resp_rdata, ref_mem[a]);
    check_bit("busy", busy, 1'b1);
    check_bit("err", err, 1'b0);
    if (expect_hit) begin
      if (rd_count != rd_before) begin
        abort_run($sformatf("Read hit at %h started a memory read", a));
      end
      if (edges != 2) begin
        abort_run($sformatf("Read hit at %h answered after %0d edges, not 2", a, edges));
      end
    end else begin
      if (rd_count != rd_before + 1) begin
        abort_run($sformatf("Read miss at %h gave %0d memory reads", a, rd_count - rd_before));
      end
      check_addr("mem_addr", rd_addr, line_base(a));
      if (rd_cycle != c0 + 2) begin
        abort_run($sformatf("Memory read for %h did not follow the lookup cycle", a));
      end
      note_refill(a);
    end
    @(posedge clk);
    #5;
    check_bit("resp_valid", resp_valid, 1'b0);
    check_bit("busy", busy, 1'b0);
  endtask

  task automatic write_word(input cache_pkg::addr_t a, input cache_pkg::data_t d);
    int wr_before;
    wait_idle();
    wr_before = wr_count;
    req_wr    = 1'b1;
    req_addr  = a;
    req_wdata = d;
    @(posedge clk);
    #5;
    req_wr = 1'b0;
    check_bit("mem_wr", mem_wr, 1'b1);
    check_bit("busy", busy, 1'b1);
    check_addr("mem_addr", mem_addr, a);
    check_data("mem_wdata", mem_wdata, d);
    @(posedge clk);
    #5;
    check_bit("mem_wr", mem_wr, 1'b0);
    check_bit("busy", busy, 1'b0);
    if (wr_count != wr_before + 1) begin
      abort_run($sformatf("Write to %h gave %0d memory writes", a, wr_count - wr_before));
    end
    ref_mem[a] = d;
  endtask

  initial begin
    cache_pkg::addr_t a;
    cache_pkg::addr_t probe;
    cache_pkg::data_t d;
    int               n;
    int               rd_before;
    int               wr_before;
    arst_n       = 1'b0;
    req_rd       = 1'b0;
    req_wr       = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    mem_silent   = 1'b0;
    shadow_valid = '0;
    shadow_tag   = '{default: '0};
    for (int i = 0; i < 256; i++) begin
      ref_mem[cache_pkg::addr_t'(i)] = cache_pkg::data_t'(next_bits(16));
    end
    repeat (4) @(posedge clk);
    #5;
    arst_n = 1'b1;

    // Outputs stay quiet until the first request
    for (int i = 0; i < 4; i++) begin
      check_bit("busy", busy, 1'b0);
      check_bit("resp_valid", resp_valid, 1'b0);
      check_bit("mem_rd", mem_rd, 1'b0);
      check_bit("mem_wr", mem_wr, 1'b0);
      check_bit("err", err, 1'b0);
      @(posedge clk);
      #5;
    end
    if (rd_count != 0 || wr_count != 0) begin
      abort_run("Memory access seen before the first request");
    end

    // Miss then hits in one line, write hit, write miss and a tag conflict
    read_word(8'h25);
    read_word(8'h26);
    read_word(8'h25);
    write_word(8'h27, 16'h1234);
    read_word(8'h27);
    write_word(8'h5b, 16'hbeef);
    read_word(8'h5b);
    write_word(8'he6, 16'h0f0f);
    read_word(8'he6);
    read_word(8'h25);

    for (int i = 0; i < random_ops; i++) begin
      a = cache_pkg::addr_t'(next_bits(8));
      if (next_bits(2) == 32'd0) begin
        d = cache_pkg::data_t'(next_bits(16));
        write_word(a, d);
      end else begin
        read_word(a);
      end
    end

    // Silent memory during a refill must end in the sticky fault
    probe      = {shadow_tag[0] + tag_w'(1), {(line_bits + word_bits){1'b0}}};
    mem_silent = 1'b1;
    rd_before  = rd_count;
    wr_before  = wr_count;
    issue_read(probe);
    n = 0;
    while (!err) begin
      @(posedge clk);
      #5;
      n++;
      if (n > timeout_cycles + 8) begin
        abort_run("err did not rise after the refill timeout");
      end
    end
    if (n < timeout_cycles) begin
      abort_run($sformatf("err rose after %0d cycles, before the refill timeout", n));
    end
    if (rd_count != rd_before + 1) begin
      abort_run("No memory read was issued before the fault");
    end
    check_bit("busy", busy, 1'b1);
    req_rd   = 1'b1;
    req_addr = 8'h25;
    @(posedge clk);
    #5;
    req_rd = 1'b0;
    for (int i = 0; i < 20; i++) begin
      check_bit("resp_valid", resp_valid, 1'b0);
      check_bit("busy", busy, 1'b1);
      check_bit("err", err, 1'b1);
      @(posedge clk);
      #5;
    end
    if (rd_count != rd_before + 1 || wr_count != wr_before) begin
      abort_run("Memory access seen after the fault");
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module cache_tb -o cache_sim

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation passed"

// File: tb.f
+incdir+dv
verilog/cache_pkg.sv
verilog/cache_memory_block.sv
verilog/cache_tag_store.sv
verilog/refill_counter.sv
verilog/cache_ctrl_fsm.sv
verilog/cache_top.sv
dv/cache_tb.sv

// File: verilog/cache_ctrl_fsm.sv
// Cache controller FSM for lookup, line refill, write-through and timeout fault
`timescale 1ns/1ns

module cache_ctrl_fsm #(
  parameter int line_bits = 3,
  parameter int word_bits = 2,
  localparam int addr_bits = line_bits + word_bits
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 req_rd,
  input  logic                 req_wr,
  input  cache_pkg::addr_t     req_addr,
  input  cache_pkg::data_t     req_wdata,
  input  logic                 hit,
  input  logic [word_bits-1:0] word,
  input  logic                 last,
  input  logic                 expired,
  input  logic                 mem_rvalid,
  input  cache_pkg::data_t     mem_rdata,
  input  cache_pkg::data_t     rd,
  output logic                 busy,
  output logic                 resp_valid,
  output cache_pkg::data_t     resp_rdata,
  output logic                 mem_rd,
  output logic                 mem_wr,
  output cache_pkg::addr_t     mem_addr,
  output cache_pkg::data_t     mem_wdata,
  output logic                 arr_we,
  output logic                 arr_re,
  output logic [addr_bits-1:0] arr_addr,
  output cache_pkg::data_t     arr_wd,
  output cache_pkg::addr_t     tag_addr,
  output logic                 fill,
  output logic                 start,
  output logic                 beat,
  output logic                 err
);

  cache_pkg::ctrl_state_t state;
  cache_pkg::ctrl_state_t state_next;
  cache_pkg::addr_t       req_addr_q;
  cache_pkg::data_t       req_wdata_q;
  logic [line_bits-1:0]   req_idx;
  logic [word_bits-1:0]   req_word;
  logic                   take;

  assign req_idx  = req_addr_q[word_bits +: line_bits];
  assign req_word = req_addr_q[word_bits-1:0];

  // Busy covers the response cycle too, so a new request waits for it
  assign busy = (state != cache_pkg::st_idle) || resp_valid;
  assign take = !busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= cache_pkg::st_idle;
      resp_valid <= 1'b0;
    end else begin
      state      <= state_next;
      resp_valid <= (state == cache_pkg::st_respond);
    end
  end

  // Request and response payload
  always_ff @(posedge clk) begin
    if (take && (req_rd || req_wr)) begin
      req_addr_q  <= req_addr;
      req_wdata_q <= req_wdata;
    end
    if (state == cache_pkg::st_respond) begin
      resp_rdata <= rd;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::st_idle: begin
        if (take && req_rd) begin
          state_next = cache_pkg::st_lookup;
        end else if (take && req_wr) begin
          state_next = cache_pkg::st_write;
        end
      end
      cache_pkg::st_lookup:     state_next = hit ? cache_pkg::st_respond : cache_pkg::st_refill_req;
      cache_pkg::st_respond:    state_next = cache_pkg::st_idle;
      cache_pkg::st_write:      state_next = cache_pkg::st_idle;
      cache_pkg::st_refill_req: state_next = cache_pkg::st_refill_wait;
      cache_pkg::st_refill_wait: begin
        // Last word goes back to lookup, which now hits
        if (mem_rvalid && last) begin
          state_next = cache_pkg::st_lookup;
        end else if (expired) begin
          state_next = cache_pkg::st_fault;
        end
      end
      cache_pkg::st_fault:      state_next = cache_pkg::st_fault;
      default:                  state_next = cache_pkg::st_idle;
    endcase
  end

  // Memory side, line base address for refills
  assign mem_rd    = (state == cache_pkg::st_refill_req);
  assign mem_wr    = (state == cache_pkg::st_write);
  assign mem_addr  = mem_wr ? req_addr_q : {req_addr_q[cache_pkg::addr_w-1:word_bits],
                                            {word_bits{1'b0}}};
  assign mem_wdata = req_wdata_q;

  // Data array, refill words land at the counter's index
  assign beat     = (state == cache_pkg::st_refill_wait) && mem_rvalid;
  assign arr_re   = (state == cache_pkg::st_lookup);
  assign arr_we   = beat || (mem_wr && hit);
  assign arr_addr = (state == cache_pkg::st_refill_wait) ? {req_idx, word} : {req_idx, req_word};
  assign arr_wd   = (state == cache_pkg::st_refill_wait) ? mem_rdata : req_wdata_q;

  assign tag_addr = req_addr_q;
  assign fill     = beat && last;
  assign start    = mem_rd;
  assign err      = (state == cache_pkg::st_fault);

endmodule

// File: verilog/cache_memory_block.sv
// Cache data array with write-first registered read, instantiated by the cache top level
`timescale 1ns/1ns

module cache_memory_block #(
  parameter int n = 32,
  localparam int addr_bits = $clog2(n)
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 we,
  input  logic                 re,
  input  logic [addr_bits-1:0] addr,
  input  cache_pkg::data_t     wd,
  output cache_pkg::data_t     rd
);

  // Storage for all lines, word-addressed
  cache_pkg::data_t mem [0:n-1];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wd;
    end
  end

  // Read register
  // A write to the same word in the read cycle is forwarded
  // Output returns to zero in any cycle after one without a read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd <= '0;
    end else if (re) begin
      if (we) begin
        rd <= wd;
      end else begin
        rd <= mem[addr];
      end
    end else begin
      rd <= '0;
    end
  end

endmodule

// File: verilog/cache_pkg.sv
// Widths, vector types and controller states shared by the cache RTL and its testbench
package cache_pkg;

  // Word address, split as tag, line index and word in line
  localparam int addr_w = 8;

  // Data word carried on both the processor and the memory side
  localparam int data_w = 16;

  // A word address as seen on the request and memory ports
  typedef logic [addr_w-1:0] addr_t;

  // One data word
  typedef logic [data_w-1:0] data_t;

  // Controller states
  // st_idle        waits for a request while busy is low
  // st_lookup      reads the array and tests the tag store
  // st_respond     hands the array word to the processor
  // st_write       write-through to memory, array update on a hit
  // st_refill_req  issues the line read to memory
  // st_refill_wait collects the words of the line
  // st_fault       sticky error after a refill timeout
  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_respond,
    st_write,
    st_refill_req,
    st_refill_wait,
    st_fault
  } ctrl_state_t;

endpackage

// File: verilog/cache_tag_store.sv
// Tag and valid store of the direct-mapped cache, gives a combinational hit for one address
`timescale 1ns/1ns

module cache_tag_store #(
  parameter int line_bits = 3,
  parameter int word_bits = 2
) (
  input  logic             clk,
  input  logic             arst_n,
  input  cache_pkg::addr_t addr,
  input  logic             fill,
  output logic             hit
);

  localparam int tag_w = cache_pkg::addr_w - line_bits - word_bits;
  localparam int lines = 1 << line_bits;

  logic [tag_w-1:0]     tag_mem [0:lines-1];
  logic [lines-1:0]     valid;
  logic [line_bits-1:0] idx;
  logic [tag_w-1:0]     tag;

  // Address fields
  assign idx = addr[word_bits +: line_bits];
  assign tag = addr[cache_pkg::addr_w-1 -: tag_w];

  // Tag written into the line on a fill
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_mem[idx] <= tag;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
    end else if (fill) begin
      valid[idx] <= 1'b1;
    end
  end

  // Compare for the currently presented address
  assign hit = valid[idx] && (tag_mem[idx] == tag);

endmodule

// File: verilog/cache_top.sv
// Top level of the write-through read cache, connects controller, refill counter and stores
`timescale 1ns/1ns

module cache_top #(
  parameter int line_bits      = 3,
  parameter int word_bits      = 2,
  parameter int timeout_cycles = 64
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             req_rd,
  input  logic             req_wr,
  input  cache_pkg::addr_t req_addr,
  input  cache_pkg::data_t req_wdata,
  output logic             busy,
  output logic             resp_valid,
  output cache_pkg::data_t resp_rdata,
  output logic             err,
  output logic             mem_rd,
  output logic             mem_wr,
  output cache_pkg::addr_t mem_addr,
  output cache_pkg::data_t mem_wdata,
  input  logic             mem_rvalid,
  input  cache_pkg::data_t mem_rdata
);

  // Array holds every word of every line
  localparam int n         = (1 << line_bits) * (1 << word_bits);
  localparam int addr_bits = $clog2(n);

  logic                 hit;
  logic [word_bits-1:0] word;
  logic                 last;
  logic                 expired;
  logic                 start;
  logic                 beat;
  logic                 fill;
  logic                 arr_we;
  logic                 arr_re;
  logic [addr_bits-1:0] arr_addr;
  cache_pkg::data_t     arr_wd;
  cache_pkg::data_t     rd;
  cache_pkg::addr_t     tag_addr;

  cache_ctrl_fsm #(
    .line_bits (line_bits),
    .word_bits (word_bits)
  ) cache_ctrl_fsm_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_rd     (req_rd),
    .req_wr     (req_wr),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .hit        (hit),
    .word       (word),
    .last       (last),
    .expired    (expired),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .rd         (rd),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .arr_we     (arr_we),
    .arr_re     (arr_re),
    .arr_addr   (arr_addr),
    .arr_wd     (arr_wd),
    .tag_addr   (tag_addr),
    .fill       (fill),
    .start      (start),
    .beat       (beat),
    .err        (err)
  );

  refill_counter #(
    .word_bits      (word_bits),
    .timeout_cycles (timeout_cycles)
  ) refill_counter_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (start),
    .beat    (beat),
    .word    (word),
    .last    (last),
    .expired (expired)
  );

  cache_tag_store #(
    .line_bits (line_bits),
    .word_bits (word_bits)
  ) cache_tag_store_i (
    .clk    (clk),
    .arst_n (arst_n),
    .addr   (tag_addr),
    .fill   (fill),
    .hit    (hit)
  );

  cache_memory_block #(
    .n (n)
  ) cache_memory_block_i (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (arr_we),
    .re     (arr_re),
    .addr   (arr_addr),
    .wd     (arr_wd),
    .rd     (rd)
  );

endmodule

// File: verilog/refill_counter.sv
// Word counter and beat watchdog for a cache line refill, driven by the cache controller
`timescale 1ns/1ns

module refill_counter #(
  parameter int word_bits      = 2,
  parameter int timeout_cycles = 64
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  logic                 beat,
  output logic [word_bits-1:0] word,
  output logic                 last,
  output logic                 expired
);

  localparam int tmr_bits = $clog2(timeout_cycles + 1);

  logic                active;
  logic [tmr_bits-1:0] timer;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word   <= '0;
      timer  <= '0;
      active <= 1'b0;
    end else if (start) begin
      word   <= '0;
      timer  <= '0;
      active <= 1'b1;
    end else if (active && beat) begin
      // Each word reloads the watchdog
      word  <= word + 1'b1;
      timer <= '0;
      if (last) begin
        active <= 1'b0;
      end
    end else if (active && !expired) begin
      timer <= timer + 1'b1;
    end
  end

  // Final word of the line
  assign last = (word == {word_bits{1'b1}});

  // Holds once reached, the controller treats it as fatal
  assign expired = active && (timer == tmr_bits'(timeout_cycles));

endmodule
